/* list.f */
design/cp_core_pkg.sv
design/cycle_sequencer.sv
design/instr_decoder.sv
design/core_regs.sv
design/execute_unit.sv
design/cp_core.sv
dv/cp_core_assert.sv
dv/cp_core_tb.sv

/* Bender.yml */
package:
  name: cp_core

sources:
  - design/cp_core_pkg.sv
  - design/cycle_sequencer.sv
  - design/instr_decoder.sv
  - design/core_regs.sv
  - design/execute_unit.sv
  - design/cp_core.sv
  - target: simulation
    files:
      - dv/cp_core_assert.sv
      - dv/cp_core_tb.sv

/* dv/cp_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cp_core_tb;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [11:0] rom_addr;
    logic [7:0]  ram_addr;
    logic [3:0]  ram_wdata;
    logic        ram_we;
    logic        carry;
    logic        zero;
    logic        instr_done;

    logic [11:0] pmem [4096];
    logic [3:0]  dmem [256];
    string       test_of [4096];  // Owning test of each program word
    int          n_instr = 0;
    string       cur_test;
    logic [15:0] lfsr = 16'd52;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // Reference model
    logic [3:0]  m_a;
    logic [3:0]  m_b;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic [3:0]  m_ram [256];
    logic        m_c;
    logic        m_z;

    cp_core UUT (.*, .rom_data(pmem[rom_addr]), .ram_rdata(dmem[ram_addr]));

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (ram_we) begin
            dmem[ram_addr] <= ram_wdata;
        end
    end

    function automatic logic [7:0] rand_bits(input int width);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);  // Galois step
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_compare(input logic [11:0] op);
        return (op ==? 12'b1010_01??_????) || (op ==? 12'b1101_11??_????)
            || (op ==? 12'b1111_0000_????);
    endfunction

    function automatic logic [3:0] opnd_value(input logic [1:0] code);
        case (code)
            2'd0:    return m_a;
            2'd1:    return m_b;
            2'd2:    return m_ram[m_x];
            default: return m_ram[m_y];
        endcase
    endfunction

    task automatic model_step(input logic [11:0] op);
        logic [3:0] lhs;
        logic [3:0] rhs;
        lhs = opnd_value(op[5:4]);  // CP r,i unless overridden below
        rhs = op[3:0];
        casez (op)
            12'hB??: m_x = op[7:0];
            12'h8??: m_y = op[7:0];
            12'b1010_01??_????: lhs = 4'({m_x, m_y} >> (12 - 4 * op[5:4]));  // XH XL YH YL
            12'b1111_0000_????: begin
                lhs = opnd_value(op[3:2]);
                rhs = opnd_value(op[1:0]);
            end
            12'b1110_00??_????: begin
                case (op[5:4])
                    2'd0:    m_a = op[3:0];
                    2'd1:    m_b = op[3:0];
                    2'd2:    m_ram[m_x] = op[3:0];
                    default: m_ram[m_y] = op[3:0];
                endcase
            end
            default: ;
        endcase
        if (is_compare(op)) begin
            m_c = lhs < rhs;
            m_z = lhs == rhs;
        end
    endtask

    task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    task automatic put(input logic [11:0] op);
        pmem[n_instr] = op;
        test_of[n_instr] = cur_test;
        n_instr++;
    endtask

    task automatic build_program();
        logic [15:0] xy;
        logic [3:0]  v;
        cur_test = "cp_xy";
        for (int rel = 0; rel < 3; rel++) begin  // greater, equal, less
            xy = {4'd1 + 4'(rand_bits(3)), 4'd1 + 4'(rand_bits(3)),
                  4'd1 + 4'(rand_bits(3)), 4'd1 + 4'(rand_bits(3))};
            put({4'hB, xy[15:8]});
            put({4'h8, xy[7:0]});
            for (int sel = 0; sel < 4; sel++) begin
                v = xy[15 - 4 * sel -: 4] + 4'(rel) - 4'd1;
                put({6'b101001, 2'(sel), v});
            end
        end
        cur_test = "cp_ri";
        put({4'hB, rand_bits(8)});
        put({4'h8, rand_bits(8)});
        for (int r = 0; r < 4; r++) begin
            v = 4'd1 + 4'(rand_bits(3));
            put({6'b111000, 2'(r), v});
            for (int rel = 0; rel < 3; rel++) begin
                put({6'b110111, 2'(r), v + 4'(rel) - 4'd1});
            end
        end
        cur_test = "cp_rq";
        for (int pair = 0; pair < 16; pair++) begin
            for (int r = 0; r < 4; r++) begin
                put({6'b111000, 2'(r), 4'(rand_bits(4))});
            end
            put({8'hF0, 4'(pair)});
        end
        cur_test = "loads";
        put({4'hB, rand_bits(8)});
        put({4'h8, rand_bits(8)});
        for (int r = 0; r < 4; r++) begin
            put({6'b111000, 2'(r), 4'(rand_bits(4))});
        end
        put({1'b0, 3'(rand_bits(3)), rand_bits(8)});
        put(12'hFFF);  // Unused opcode
        cur_test = "random";
        for (int k = 0; k < 200; k++) begin
            case (rand_bits(3))
                0:       put({4'hB, rand_bits(8)});
                1:       put({4'h8, rand_bits(8)});
                2:       put({6'b111000, 6'(rand_bits(6))});
                3:       put({6'b101001, 6'(rand_bits(6))});
                4:       put({6'b110111, 6'(rand_bits(6))});
                5:       put({8'hF0, 4'(rand_bits(4))});
                default: put({1'b0, 3'(rand_bits(3)), rand_bits(8)});
            endcase
        end
    endtask

    initial begin
        int          cycles;
        logic [11:0] op;
        for (int i = 0; i < 4096; i++) begin  // No-op fill
            pmem[i] = {1'b0, 3'(i[11:9] ^ i[8:6]), 8'(i) ^ 8'(i >> 8)};
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 4'(i) ^ 4'(i >> 4);
            m_ram[i] = 4'(i) ^ 4'(i >> 4);
        end
        {m_a, m_b, m_x, m_y, m_c, m_z} = '0;
        build_program();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        cur_test = "reset";
        check("instr_done", 0, instr_done);
        check("ram_we", 0, ram_we);
        check("carry", 0, carry);
        check("zero", 0, zero);
        check("rom_addr", 0, rom_addr);
        end_test(cur_test);

        cycles = 1;
        for (int k = 0; k < n_instr; k++) begin
            cur_test = test_of[k];
            op = pmem[k];
            while (instr_done !== 1'b1) begin
                @(negedge clk);
                cycles++;
                if (cycles > 2 * cp_core_pkg::cp_cycles) begin
                    $display("Timeout in test %s: instruction %0d never finished", cur_test, k);
                    $display("Test FAILED");
                    $finish;
                end
            end
            check("pc", k, rom_addr);
            check("cycles", is_compare(op) ? 7 : 5, cycles);
            model_step(op);
            @(negedge clk);  // Results land at the edge ending instr_done
            check("carry", m_c, carry);
            check("zero", m_z, zero);
            check("registers", {m_a, m_b, m_x, m_y}, UUT.view);
            for (int i = 0; i < 256; i++) begin
                check($sformatf("ram[%02h]", i), m_ram[i], dmem[i]);
            end
            cycles = 1;
            if (k == n_instr - 1 || test_of[k + 1] != cur_test) begin
                end_test(cur_test);
            end
        end

        cur_test = "assertions";
        check("failures", 0, UUT.checks.failures);
        end_test(cur_test);
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cp_core_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module cp_core_assert (
    input logic        clk,
    input logic        reset,
    input logic [11:0] rom_addr,
    input logic [11:0] rom_data,
    input logic        ram_we,
    input logic        carry,
    input logic        zero,
    input logic        instr_done
);

    int         failures = 0;
    logic [3:0] gap;  // Cycle number within the instruction counting from 1
    logic       cp_now;

    task automatic count_failure(input string what);
        $error("%s", what);
        failures++;
    endtask

    // Current instruction is a compare
    assign cp_now = (rom_data ==? 12'b1010_01??_????) || (rom_data ==? 12'b1101_11??_????)
                 || (rom_data ==? 12'b1111_0000_????);

    always_ff @(posedge clk) begin
        if (reset || instr_done) begin
            gap <= 4'd1;
        end else begin
            gap <= gap + 4'd1;
        end
    end

    spacing: assert property (@(posedge clk) disable iff (reset)
        instr_done |-> gap inside {4'(cp_core_pkg::ld_cycles), 4'(cp_core_pkg::cp_cycles)})
        else count_failure("instr_done spacing is neither an LD nor a CP length");

    pc_step: assert property (@(posedge clk) disable iff (reset)
        instr_done |=> rom_addr == $past(rom_addr) + 12'd1)
        else count_failure("rom_addr did not step by one after instr_done");

    pc_hold: assert property (@(posedge clk) disable iff (reset)
        !instr_done |=> $stable(rom_addr))
        else count_failure("rom_addr moved inside an instruction");

    flags_hold: assert property (@(posedge clk) disable iff (reset)
        !(instr_done && cp_now) |=> $stable(carry) && $stable(zero))
        else count_failure("carry or zero changed outside the end of a compare");

    // RAM is written only in the final cycle of LD MX,i or LD MY,i
    we_in_done: assert property (@(posedge clk) disable iff (reset)
        ram_we == (instr_done && (rom_data ==? 12'b1110_001?_????)))
        else count_failure("ram_we does not match the final cycle of an LD to MX or MY");

    reset_values: assert property (@(posedge clk)
        reset |=> !instr_done && !ram_we && !carry && !zero && rom_addr == 12'd0)
        else count_failure("outputs not cleared by reset");

endmodule

bind cp_core cp_core_assert checks (.*);

`default_nettype wire

/* design/cp_core.sv */
`timescale 1ns/100ps
`default_nettype none

module cp_core (
    input  logic                                clk,
    input  logic                                reset,
    output logic [cp_core_pkg::pc_w-1:0]        rom_addr,
    input  logic [cp_core_pkg::opcode_w-1:0]    rom_data,
    output logic [cp_core_pkg::index_w-1:0]     ram_addr,
    input  logic [cp_core_pkg::nibble_w-1:0]    ram_rdata,
    output logic [cp_core_pkg::nibble_w-1:0]    ram_wdata,
    output logic                                ram_we,
    output logic                                carry,
    output logic                                zero,
    output logic                                instr_done
);

    logic                    fetch;
    logic                    last;
    cp_core_pkg::decoded_t   dec;
    cp_core_pkg::reg_write_t wr;
    cp_core_pkg::reg_view_t  view;

    cycle_sequencer seq (
        .clk   (clk),
        .reset (reset),
        .kind  (dec.kind),
        .fetch (fetch),
        .last  (last)
    );

    instr_decoder decoder (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .rom_data (rom_data),
        .dec      (dec)
    );

    core_regs regs (
        .clk   (clk),
        .reset (reset),
        .last  (last),
        .wr    (wr),
        .view  (view),
        .pc    (rom_addr)  // Fetch straight from the PC
    );

    execute_unit exec (
        .clk       (clk),
        .reset     (reset),
        .last      (last),
        .dec       (dec),
        .view      (view),
        .ram_rdata (ram_rdata),
        .wr        (wr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .carry     (carry),
        .zero      (zero)
    );

    assign instr_done = last;

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                last,
    input  cp_core_pkg::decoded_t               dec,
    input  cp_core_pkg::reg_view_t              view,
    input  logic [cp_core_pkg::nibble_w-1:0]    ram_rdata,
    output cp_core_pkg::reg_write_t             wr,
    output logic [cp_core_pkg::index_w-1:0]     ram_addr,
    output logic [cp_core_pkg::nibble_w-1:0]    ram_wdata,
    output logic                                ram_we,
    output logic                                carry,
    output logic                                zero
);

    logic [cp_core_pkg::nibble_w-1:0] mem_q;  // RAM nibble of the first operand
    logic [cp_core_pkg::nibble_w-1:0] op1;
    logic [cp_core_pkg::nibble_w-1:0] op2;
    logic [cp_core_pkg::index_w-1:0]  dst_addr;
    logic [cp_core_pkg::index_w-1:0]  src_addr;
    logic                             dst_is_mem;

    function automatic logic [cp_core_pkg::nibble_w-1:0] pick(
        input logic [1:0]                       code,
        input cp_core_pkg::reg_view_t           v,
        input logic [cp_core_pkg::nibble_w-1:0] mem
    );
        case (code)
            cp_core_pkg::opnd_a: pick = v.a;
            cp_core_pkg::opnd_b: pick = v.b;
            default:             pick = mem;  // MX or MY
        endcase
    endfunction

    assign dst_addr   = (dec.dst == cp_core_pkg::opnd_my) ? view.y : view.x;
    assign src_addr   = (dec.src == cp_core_pkg::opnd_my) ? view.y : view.x;
    assign dst_is_mem = (dec.dst == cp_core_pkg::opnd_mx) || (dec.dst == cp_core_pkg::opnd_my);

    // One RAM port reads r before the final cycle and q during it
    assign ram_addr = (last && dec.kind == cp_core_pkg::cp_rq) ? src_addr : dst_addr;

    always_ff @(posedge clk) begin
        if (!last) begin
            mem_q <= ram_rdata;
        end
    end

    always_comb begin
        case (dec.kind)
            cp_core_pkg::cp_xh: op1 = view.x[7:4];
            cp_core_pkg::cp_xl: op1 = view.x[3:0];
            cp_core_pkg::cp_yh: op1 = view.y[7:4];
            cp_core_pkg::cp_yl: op1 = view.y[3:0];
            default:            op1 = pick(dec.dst, view, mem_q);
        endcase
    end

    assign op2 = (dec.kind == cp_core_pkg::cp_rq) ? pick(dec.src, view, ram_rdata) : dec.imm4;

    // Unsigned compare with carry on borrow
    always_ff @(posedge clk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (last && cp_core_pkg::is_cp(dec.kind)) begin
            carry <= (op1 < op2);
            zero  <= (op1 == op2);
        end
    end

    // Register writes land in core_regs at last
    assign wr.wr_a  = (dec.kind == cp_core_pkg::ld_r) && (dec.dst == cp_core_pkg::opnd_a);
    assign wr.wr_b  = (dec.kind == cp_core_pkg::ld_r) && (dec.dst == cp_core_pkg::opnd_b);
    assign wr.wr_x  = (dec.kind == cp_core_pkg::ld_x);
    assign wr.wr_y  = (dec.kind == cp_core_pkg::ld_y);
    assign wr.data4 = dec.imm4;
    assign wr.data8 = dec.imm8;

    assign ram_wdata = dec.imm4;
    assign ram_we    = last && (dec.kind == cp_core_pkg::ld_r) && dst_is_mem;

endmodule

`default_nettype wire

/* design/core_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module core_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         last,
    input  cp_core_pkg::reg_write_t      wr,
    output cp_core_pkg::reg_view_t       view,
    output logic [cp_core_pkg::pc_w-1:0] pc
);

    logic [cp_core_pkg::nibble_w-1:0] a;
    logic [cp_core_pkg::nibble_w-1:0] b;
    logic [cp_core_pkg::index_w-1:0]  x;
    logic [cp_core_pkg::index_w-1:0]  y;

    // All architectural state moves on the final cycle only
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            a  <= '0;
            b  <= '0;
            x  <= '0;
            y  <= '0;
        end else if (last) begin
            pc <= pc + 1'b1;

            if (wr.wr_a) begin
                a <= wr.data4;
            end
            if (wr.wr_b) begin
                b <= wr.data4;
            end
            if (wr.wr_x) begin
                x <= wr.data8;
            end
            if (wr.wr_y) begin
                y <= wr.data8;
            end
        end
    end

    assign view.a = a;
    assign view.b = b;
    assign view.x = x;
    assign view.y = y;

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fetch,
    input  logic [cp_core_pkg::opcode_w-1:0] rom_data,
    output cp_core_pkg::decoded_t            dec
);

    logic [cp_core_pkg::opcode_w-1:0] ir;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;  // Decodes as a no-op
        end else if (fetch) begin
            ir <= rom_data;
        end
    end

    always_comb begin
        dec      = '0;
        dec.kind = cp_core_pkg::nop;
        dec.imm4 = ir[3:0];
        dec.imm8 = ir[7:0];

        if (ir[11:8] == cp_core_pkg::op_ld_x) begin
            dec.kind = cp_core_pkg::ld_x;
        end else if (ir[11:8] == cp_core_pkg::op_ld_y) begin
            dec.kind = cp_core_pkg::ld_y;
        end else if (ir[11:4] == cp_core_pkg::op_cp_xh) begin
            dec.kind = cp_core_pkg::cp_xh;
        end else if (ir[11:4] == cp_core_pkg::op_cp_xl) begin
            dec.kind = cp_core_pkg::cp_xl;
        end else if (ir[11:4] == cp_core_pkg::op_cp_yh) begin
            dec.kind = cp_core_pkg::cp_yh;
        end else if (ir[11:4] == cp_core_pkg::op_cp_yl) begin
            dec.kind = cp_core_pkg::cp_yl;
        end else if (ir[11:6] == cp_core_pkg::op_cp_ri) begin
            dec.kind = cp_core_pkg::cp_ri;
            dec.dst  = ir[5:4];
        end else if (ir[11:6] == cp_core_pkg::op_ld_r) begin
            dec.kind = cp_core_pkg::ld_r;
            dec.dst  = ir[5:4];
        end else if (ir[11:4] == cp_core_pkg::op_cp_rq) begin
            dec.kind = cp_core_pkg::cp_rq;
            dec.dst  = ir[3:2];  // r
            dec.src  = ir[1:0];  // q
        end
    end

endmodule

`default_nettype wire

/* design/cycle_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cycle_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  cp_core_pkg::op_kind_e kind,
    output logic                  fetch,
    output logic                  last
);

    typedef logic [$clog2(cp_core_pkg::cp_cycles)-1:0] cnt_t;

    cnt_t cnt;
    cnt_t cnt_next;
    cnt_t final_cnt;  // Index of the final cycle

    assign cnt_next = last ? '0 : cnt + 1'b1;

    // fetch and last come out of flops one cycle ahead of the count
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= '0;
            final_cnt <= cnt_t'(cp_core_pkg::ld_cycles - 1);
            fetch     <= 1'b1;  // First fetch right after reset
            last      <= 1'b0;
        end else begin
            cnt   <= cnt_next;
            fetch <= last;
            last  <= (cnt_next == final_cnt);

            // Decoded kind is valid from cycle 1
            if (cnt == cnt_t'(1)) begin
                if (cp_core_pkg::is_cp(kind)) begin
                    final_cnt <= cnt_t'(cp_core_pkg::cp_cycles - 1);
                end else begin
                    final_cnt <= cnt_t'(cp_core_pkg::ld_cycles - 1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cp_core_pkg.sv */
`default_nettype none

package cp_core_pkg;

    localparam int nibble_w = 4;
    localparam int opcode_w = 12;
    localparam int pc_w     = 12;
    localparam int index_w  = 8;

    // Instruction lengths in clock cycles
    localparam int ld_cycles = 5;
    localparam int cp_cycles = 7;

    // Opcode prefixes matched on the upper bits
    localparam logic [3:0] op_ld_y  = 4'h8;       // 8ee
    localparam logic [3:0] op_ld_x  = 4'hB;       // Bee
    localparam logic [7:0] op_cp_xh = 8'hA4;
    localparam logic [7:0] op_cp_xl = 8'hA5;
    localparam logic [7:0] op_cp_yh = 8'hA6;
    localparam logic [7:0] op_cp_yl = 8'hA7;
    localparam logic [5:0] op_cp_ri = 6'b110111;  // DC0..DFF
    localparam logic [5:0] op_ld_r  = 6'b111000;  // E00..E3F
    localparam logic [7:0] op_cp_rq = 8'hF0;      // F00..F0F

    // Operand codes for r and q
    localparam logic [1:0] opnd_a  = 2'd0;
    localparam logic [1:0] opnd_b  = 2'd1;
    localparam logic [1:0] opnd_mx = 2'd2;
    localparam logic [1:0] opnd_my = 2'd3;

    typedef enum logic [3:0] {
        ld_x, ld_y, ld_r,
        cp_xh, cp_xl, cp_yh, cp_yl,
        cp_ri, cp_rq,
        nop
    } op_kind_e;

    typedef struct packed {
        op_kind_e            kind;
        logic [1:0]          dst;
        logic [1:0]          src;
        logic [nibble_w-1:0] imm4;
        logic [index_w-1:0]  imm8;
    } decoded_t;

    typedef struct packed {
        logic                wr_a;
        logic                wr_b;
        logic                wr_x;
        logic                wr_y;
        logic [nibble_w-1:0] data4;
        logic [index_w-1:0]  data8;
    } reg_write_t;

    typedef struct packed {
        logic [nibble_w-1:0] a;
        logic [nibble_w-1:0] b;
        logic [index_w-1:0]  x;
        logic [index_w-1:0]  y;
    } reg_view_t;

    function automatic logic is_cp(input op_kind_e kind);
        return kind inside {cp_xh, cp_xl, cp_yh, cp_yl, cp_ri, cp_rq};
    endfunction

endpackage

`default_nettype wire
